// ==== files.f ====
+incdir+verilog
verilog/hawk_pkg.sv
verilog/wr_resp_tracker.sv
verilog/tol_list_regs.sv
verilog/init_line_builder.sv
verilog/upd_line_builder.sv
verilog/pgwr_fsm.sv
verilog/hawk_pgwr_mngr.sv
verification/tb_hawk_pgwr_mngr.sv

// ==== verification/tb_hawk_pgwr_mngr.sv ====
// page-write manager testbench with seeded random ready and response timing
// byte-memory model covers the att and list regions only (512 bytes from the att base)
// the last test leaves the fsm in WAIT_RESP behind a bad response
`include "hawk_consts.svh"

module tb_hawk_pgwr_mngr;
	import hawk_pkg::*;

	localparam int unsigned MAX_CYC = 2000; // ~40 writes with long random stalls
	localparam int unsigned WIN_B   = 512;  // att lines at 0 and list lines at 256
	localparam int unsigned LST_OFF = 256;

	logic      clk_i = 1'b0;
	logic      rst_ni;
	logic      init_att, init_list, tbl_update;
	att_id_t   att_entry_id;
	lst_id_t   tol_entry_id, lst_prev, lst_next;
	list_sel_e src_list, dst_list;
	way_t      lst_way;
	logic      awready, wready, bvalid;
	resp_t     bresp;
	logic      awvalid, wvalid;
	addr_t     addr;
	line_t     data;
	strb_t     strb;
	logic      ready, init_att_done, init_list_done, tbl_update_done, bus_error;
	lst_id_t   free_head, free_tail, uncomp_head, uncomp_tail;

	logic [7:0]  mem [WIN_B];  // model memory
	int unsigned due_q[$];     // response cycles in order
	int unsigned cyc, due, last_due;
	int unsigned wr_cnt, done_cnt;
	logic        bad_next;     // next response gets an error code
	lst_id_t     exp_fh, exp_uh, exp_ut; // model list pointers

	hawk_pgwr_mngr hawk_pgwr_mngr_i (.*);

	always #20 clk_i = ~clk_i;

	// ready lines and responses all driven on the rising edge
	always @(posedge clk_i) begin
		cyc = cyc + 1;
		if (cyc > MAX_CYC) begin
			$display("timeout: run still going after %0d cycles", MAX_CYC);
			$display("Simulation finished: FAIL");
			$fatal(1, "cycle limit reached");
		end else begin
			awready <= ($urandom % 10) < 7; // ~70% high
			wready  <= ($urandom % 10) < 7;
			if (due_q.size() > 0 && due_q[0] <= cyc) begin
				bvalid   <= 1'b1;
				bresp    <= bad_next ? 2'd2 : 2'd0; // slverr when armed
				bad_next = 1'b0;
				void'(due_q.pop_front());
			end else begin
				bvalid <= 1'b0;
				bresp  <= 2'd0;
			end
		end
	end

	// bus monitor sampled mid-cycle
	always @(negedge clk_i) begin
		if (awvalid && awready) begin
			due = cyc + 1 + $urandom % 4;   // random latency
			if (due <= last_due) begin
				due = last_due + 1;          // in order and one per cycle
			end
			last_due = due;
			due_q.push_back(due);
		end
		if (wvalid) begin
			store_line();
			wr_cnt++;
		end
		if (tbl_update_done) begin
			done_cnt++;
		end
	end

	function automatic logic [7:0] fill_byte(int unsigned i);
		return 8'(i) ^ 8'(i >> 8) ^ 8'h3c; // all index bits matter
	endfunction

	task automatic store_line();
		addr_t off;
		int    b;
		off = addr - `HAWK_ATT_BASE;
		if (off > WIN_B - `LINE_BYTES) begin
			$display("write to address %h lies outside the table window", addr);
			$display("Simulation finished: FAIL");
			$fatal(1, "bad write address");
		end else begin
			for (b = 0; b < `LINE_BYTES; b++) begin
				if (strb[b]) begin
					mem[off + b] = data[b*8 +: 8]; // strobed bytes only
				end
			end
		end
	endtask

	function automatic logic [63:0] att_at(int unsigned n);
		logic [63:0] v;
		int          b;
		for (b = 0; b < 8; b++) begin
			v[b*8 +: 8] = mem[(n - 1) * 8 + b]; // little-endian lane
		end
		return v;
	endfunction

	function automatic logic [127:0] lst_at(int unsigned n);
		logic [127:0] v;
		int           b;
		for (b = 0; b < 16; b++) begin
			v[b*8 +: 8] = mem[LST_OFF + (n - 1) * 16 + b];
		end
		return v;
	endfunction

	task automatic check_eq(input string what, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	// one-cycle request strobe with its fields
	task automatic send_update(input att_id_t aid, input lst_id_t id, input list_sel_e dst,
			input way_t way, input lst_id_t succ);
		@(posedge clk_i);
		tbl_update   <= 1'b1;
		att_entry_id <= aid;
		tol_entry_id <= id;
		src_list     <= FREE;
		dst_list     <= dst;
		lst_way      <= way;
		lst_prev     <= '0;   // successor becomes free head
		lst_next     <= succ;
		@(posedge clk_i);
		tbl_update <= 1'b0;
	endtask

	// pop the free head, push to uncomp when dst says so, then check memory and pointers
	task automatic run_update(input list_sel_e dst);
		att_id_t      aid;
		way_t         way;
		lst_id_t      id, succ, old_tail;
		logic [127:0] ent;
		int unsigned  wr0, done0, n_wr;
		aid      = att_id_t'(1 + $urandom % `ATT_ENTRY_CNT);
		way      = way_t'({$urandom, $urandom});
		id       = exp_fh;
		succ     = (id == `LIST_ENTRY_CNT) ? '0 : id + 1; // free list is still sequential
		old_tail = exp_ut;
		n_wr     = (dst != UNCOMP) ? 2 : ((old_tail == '0) ? 3 : 4);
		wr0      = wr_cnt;
		done0    = done_cnt;
		send_update(aid, id, dst, way, succ);
		do @(negedge clk_i); while (!tbl_update_done);
		@(negedge clk_i);
		check_eq("ready after update", ready, 1'b1);
		check_eq("done pulses", done_cnt - done0, 1);
		check_eq("update writes", wr_cnt - wr0, n_wr);
		check_eq("att entry", att_at(aid), {12'b0, way, (dst == UNCOMP) ? 2'd1 : 2'd0});
		ent = lst_at(succ);
		check_eq("successor prev", ent[63:32], 32'd0);
		exp_fh = succ;
		if (dst == UNCOMP) begin
			ent = lst_at(id);
			check_eq("new tail prev", ent[63:32], old_tail);
			check_eq("new tail next", ent[31:0], 32'd0);
			if (old_tail != '0) begin
				ent = lst_at(old_tail);
				check_eq("old tail next", ent[31:0], id); // link path
			end else begin
				exp_uh = id; // empty-list path
			end
			exp_ut = id;
		end
		check_eq("free_head", free_head, exp_fh);
		check_eq("free_tail", free_tail, `LIST_ENTRY_CNT);
		check_eq("uncomp_head", uncomp_head, exp_uh);
		check_eq("uncomp_tail", uncomp_tail, exp_ut);
		check_eq("bus_error", bus_error, 1'b0);
	endtask

	initial begin
		int unsigned  seed_ret;
		int unsigned  i;
		logic [127:0] ent;
		seed_ret = $urandom(32'h8525fecb);
		cyc      = 0;
		last_due = 0;
		wr_cnt   = 0;
		done_cnt = 0;
		bad_next = 1'b0;
		for (i = 0; i < WIN_B; i++) begin
			mem[i] = fill_byte(i);
		end
		rst_ni       <= 1'b0;
		init_att     <= 1'b0;
		init_list    <= 1'b0;
		tbl_update   <= 1'b0;
		att_entry_id <= '0;
		tol_entry_id <= '0;
		src_list     <= FREE;
		dst_list     <= FREE;
		lst_way      <= '0;
		lst_prev     <= '0;
		lst_next     <= '0;
		awready      <= 1'b0;
		wready       <= 1'b0;
		bvalid       <= 1'b0;
		bresp        <= 2'd0;
		repeat (5) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(negedge clk_i);
		check_eq("awvalid after reset", awvalid, 1'b0);
		check_eq("wvalid after reset", wvalid, 1'b0);
		check_eq("done flags after reset", {init_att_done, init_list_done, tbl_update_done}, 0);
		check_eq("bus_error after reset", bus_error, 1'b0);
		check_eq("pointers after reset", {free_head, free_tail, uncomp_head, uncomp_tail}, 0);
		check_eq("ready after reset", ready, 1'b1);

		// init-att level held until done
		@(posedge clk_i);
		init_att <= 1'b1;
		do @(negedge clk_i); while (!init_att_done);
		@(posedge clk_i);
		init_att <= 1'b0;
		@(negedge clk_i);
		for (i = 1; i <= `ATT_ENTRY_CNT; i++) begin
			check_eq("att entry after init", att_at(i), 64'h0); // dalloc with way 0
		end
		for (i = `ATT_ENTRY_CNT * 8; i < WIN_B; i++) begin
			check_eq("byte outside att strobes", mem[i], fill_byte(i));
		end

		// init-list
		@(posedge clk_i);
		init_list <= 1'b1;
		do @(negedge clk_i); while (!init_list_done);
		@(posedge clk_i);
		init_list <= 1'b0;
		@(negedge clk_i);
		for (i = 1; i <= `LIST_ENTRY_CNT; i++) begin
			ent = {14'b0, way_t'(`HAWK_PPA_BASE + i - 1), 32'(i - 1),
				(i == `LIST_ENTRY_CNT) ? 32'd0 : 32'(i + 1)};
			check_eq("list entry after init", lst_at(i), ent);
		end
		for (i = LST_OFF + `LIST_ENTRY_CNT * 16; i < WIN_B; i++) begin
			check_eq("byte outside list strobes", mem[i], fill_byte(i));
		end
		check_eq("free_head after init", free_head, 32'd1);
		check_eq("free_tail after init", free_tail, `LIST_ENTRY_CNT);
		exp_fh = 1;
		exp_uh = '0;
		exp_ut = '0;

		repeat (3) run_update(UNCOMP); // first the empty path and then the link path
		run_update(COMP);              // att and pop only

		// error response on the next write
		bad_next = 1'b1;
		send_update(att_id_t'(1), exp_fh, COMP, '0, exp_fh + 1);
		do @(negedge clk_i); while (!bus_error);
		repeat (10) @(negedge clk_i);
		check_eq("bus_error sticky", bus_error, 1'b1);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== verilog/hawk_pgwr_mngr.sv ====
// page-write manager top, wiring only
// single-beat writes, one outstanding aw/w pair at a time from the fsm
// responses must come back in order, bready is implied
module hawk_pgwr_mngr (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic                init_att,
	input  logic                init_list,
	input  logic                tbl_update,
	input  hawk_pkg::att_id_t   att_entry_id,
	input  hawk_pkg::lst_id_t   tol_entry_id,
	input  hawk_pkg::list_sel_e src_list,
	input  hawk_pkg::list_sel_e dst_list,
	input  hawk_pkg::way_t      lst_way,
	input  hawk_pkg::lst_id_t   lst_prev,  // new prev of popped successor
	input  hawk_pkg::lst_id_t   lst_next,  // successor of popped entry
	input  logic                awready,
	input  logic                wready,
	input  logic                bvalid,
	input  hawk_pkg::resp_t     bresp,
	output logic                awvalid,
	output logic                wvalid,
	output hawk_pkg::addr_t     addr,
	output hawk_pkg::line_t     data,
	output hawk_pkg::strb_t     strb,
	output logic                ready,
	output logic                init_att_done,
	output logic                init_list_done,
	output logic                tbl_update_done,
	output hawk_pkg::lst_id_t   free_head,
	output hawk_pkg::lst_id_t   free_tail,
	output hawk_pkg::lst_id_t   uncomp_head,
	output hawk_pkg::lst_id_t   uncomp_tail,
	output logic                bus_error
);
	import hawk_pkg::*;

	addr_t     init_addr, upd_addr;
	line_t     init_data, upd_data;
	strb_t     init_strb, upd_strb;
	att_id_t   init_entry;
	logic      init_is_list;
	upd_step_e upd_step;
	att_id_t   upd_att_id;
	lst_id_t   upd_tol_id, upd_prev, upd_next;
	list_sel_e upd_dst;
	way_t      upd_way;
	logic      all_resp_done, uncomp_empty;
	logic      init_list_end, pop_free, push_uncomp;

	pgwr_fsm pgwr_fsm_i (.*); // port names match the wires above

	init_line_builder init_line_builder_i (
		.init_entry, .init_is_list,
		.addr(init_addr), .data(init_data), .strb(init_strb)
	);

	upd_line_builder upd_line_builder_i (
		.upd_step, .upd_att_id, .upd_tol_id, .upd_dst, .upd_way, .upd_prev, .upd_next,
		.uncomp_tail, .addr(upd_addr), .data(upd_data), .strb(upd_strb)
	);

	tol_list_regs tol_list_regs_i (
		.clk_i, .rst_ni, .init_list_end, .pop_free, .pop_next(upd_next),
		.push_uncomp, .push_id(upd_tol_id),
		.free_head, .free_tail, .uncomp_head, .uncomp_tail, .uncomp_empty
	);

	wr_resp_tracker wr_resp_tracker_i (
		.clk_i, .rst_ni, .awvalid, .awready, .bvalid, .bresp, .all_resp_done, .bus_error
	);

endmodule

// ==== verilog/pgwr_fsm.sv ====
// sequencer for init-att, init-list and table update
// aw only issued while awready is high and awvalid low, w likewise on wready
// init writes do not wait for responses, updates drain them in WAIT_RESP
`include "hawk_consts.svh"

module pgwr_fsm (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic                init_att,
	input  logic                init_list,
	input  logic                tbl_update,
	input  hawk_pkg::att_id_t   att_entry_id,
	input  hawk_pkg::lst_id_t   tol_entry_id,
	input  hawk_pkg::list_sel_e src_list,
	input  hawk_pkg::list_sel_e dst_list,
	input  hawk_pkg::way_t      lst_way,
	input  hawk_pkg::lst_id_t   lst_prev,
	input  hawk_pkg::lst_id_t   lst_next,
	input  logic                awready,
	input  logic                wready,
	input  logic                all_resp_done,
	input  logic                uncomp_empty,
	input  hawk_pkg::addr_t     init_addr,
	input  hawk_pkg::line_t     init_data,
	input  hawk_pkg::strb_t     init_strb,
	input  hawk_pkg::addr_t     upd_addr,
	input  hawk_pkg::line_t     upd_data,
	input  hawk_pkg::strb_t     upd_strb,
	output logic                awvalid,
	output logic                wvalid,
	output hawk_pkg::addr_t     addr,
	output hawk_pkg::line_t     data,
	output hawk_pkg::strb_t     strb,
	output logic                ready,
	output logic                init_att_done,
	output logic                init_list_done,
	output logic                tbl_update_done,
	output hawk_pkg::att_id_t   init_entry,
	output logic                init_is_list,
	output hawk_pkg::upd_step_e upd_step,
	output hawk_pkg::att_id_t   upd_att_id,
	output hawk_pkg::lst_id_t   upd_tol_id,
	output hawk_pkg::list_sel_e upd_dst,
	output hawk_pkg::way_t      upd_way,
	output hawk_pkg::lst_id_t   upd_prev,
	output hawk_pkg::lst_id_t   upd_next,
	output logic                init_list_end, // free list pointers load
	output logic                pop_free,
	output logic                push_uncomp
);
	import hawk_pkg::*;

	pgwr_state_e state_q, state_d;
	upd_step_e   step_q, step_d;
	att_id_t     cnt_q, cnt_d;    // current entry id in init modes
	list_sel_e   upd_src;
	logic        aw_go, w_go;     // free slot on each channel
	logic        issue, send_w, start_upd, att_done_set;

	assign aw_go = awready && !awvalid;
	assign w_go  = wready && !wvalid;

	always_comb begin
		state_d       = state_q;
		step_d        = step_q;
		cnt_d         = cnt_q;
		issue         = 1'b0;
		send_w        = 1'b0;
		start_upd     = 1'b0;
		att_done_set  = 1'b0;
		init_list_end = 1'b0;
		pop_free      = 1'b0;
		push_uncomp   = 1'b0;
		case (state_q)
			IDLE: begin
				// init requests win over updates
				if (init_att && !init_att_done) begin
					state_d = INIT_ATT;
					cnt_d   = att_id_t'(1);
				end else if (init_list && !init_list_done) begin
					state_d = INIT_LIST;
					cnt_d   = att_id_t'(1);
				end else if (tbl_update) begin
					state_d   = UPD_AW;
					step_d    = ATT_WR;
					start_upd = 1'b1;
				end
			end
			INIT_ATT: begin
				if (aw_go) begin
					if (cnt_q <= att_id_t'(`ATT_ENTRY_CNT)) begin
						issue   = 1'b1;
						cnt_d   = cnt_q + 1'b1;
						state_d = WAIT_ATT;
					end else begin
						att_done_set = 1'b1; // all entries sent
						state_d      = IDLE;
					end
				end
			end
			INIT_LIST: begin
				if (aw_go) begin
					if (cnt_q <= att_id_t'(`LIST_ENTRY_CNT)) begin
						issue   = 1'b1;
						cnt_d   = cnt_q + 1'b1;
						state_d = WAIT_LIST;
					end else begin
						init_list_end = 1'b1;
						state_d       = IDLE;
					end
				end
			end
			WAIT_ATT, WAIT_LIST: begin
				if (w_go) begin
					send_w  = 1'b1;
					state_d = (state_q == WAIT_ATT) ? INIT_ATT : INIT_LIST;
				end
			end
			UPD_AW: begin
				if (aw_go) begin
					issue   = 1'b1;
					state_d = UPD_W;
				end
			end
			UPD_W: begin
				if (w_go) begin
					send_w  = 1'b1;
					state_d = UPD_AW;
					case (step_q)
						ATT_WR: step_d = POP_WR;
						POP_WR: begin
							pop_free = (upd_src == FREE); // other sources keep head
							if (upd_dst == UNCOMP) begin
								step_d = PUSH_SELF_WR;
							end else begin
								state_d = WAIT_RESP; // no push
							end
						end
						PUSH_SELF_WR: begin
							if (uncomp_empty) begin
								push_uncomp = 1'b1; // becomes head and tail
								state_d     = WAIT_RESP;
							end else begin
								step_d = PUSH_LINK_WR;
							end
						end
						default: begin
							push_uncomp = 1'b1; // old tail now linked
							state_d     = WAIT_RESP;
						end
					endcase
				end
			end
			WAIT_RESP: begin
				if (all_resp_done) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	assign ready           = (state_q == IDLE);
	assign tbl_update_done = (state_q == WAIT_RESP) && all_resp_done;
	assign init_entry      = cnt_q;
	assign init_is_list    = (state_q == INIT_LIST);
	assign upd_step        = step_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q        <= IDLE;
			step_q         <= ATT_WR;
			cnt_q          <= '0;
			awvalid        <= 1'b0;
			wvalid         <= 1'b0;
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
		end else begin
			state_q <= state_d;
			step_q  <= step_d;
			cnt_q   <= cnt_d;
			awvalid <= issue;  // one-cycle pulses
			wvalid  <= send_w;
			if (att_done_set) begin
				init_att_done <= 1'b1;
			end
			if (init_list_end) begin
				init_list_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (issue) begin
			addr <= (state_q == UPD_AW) ? upd_addr : init_addr; // held till next request
			data <= (state_q == UPD_AW) ? upd_data : init_data;
			strb <= (state_q == UPD_AW) ? upd_strb : init_strb;
		end
		if (start_upd) begin
			upd_att_id <= att_entry_id;
			upd_tol_id <= tol_entry_id;
			upd_src    <= src_list;
			upd_dst    <= dst_list;
			upd_way    <= lst_way;
			upd_prev   <= lst_prev;
			upd_next   <= lst_next;
		end
	end

endmodule

// ==== verilog/upd_line_builder.sv ====
// partial-line write for each table update step, combinational
// list pointers are byte lanes 0..3 (next) and 4..7 (prev) of an entry
// uncomp_tail must still be the old tail during both push steps
`include "hawk_consts.svh"

module upd_line_builder (
	input  hawk_pkg::upd_step_e upd_step,
	input  hawk_pkg::att_id_t   upd_att_id,
	input  hawk_pkg::lst_id_t   upd_tol_id,
	input  hawk_pkg::list_sel_e upd_dst,
	input  hawk_pkg::way_t      upd_way,
	input  hawk_pkg::lst_id_t   upd_prev,
	input  hawk_pkg::lst_id_t   upd_next,
	input  hawk_pkg::lst_id_t   uncomp_tail,
	output hawk_pkg::addr_t     addr,
	output hawk_pkg::line_t     data,
	output hawk_pkg::strb_t     strb
);
	import hawk_pkg::*;

	localparam int unsigned ATT_B = $bits(att_entry_t) / 8;
	localparam int unsigned LST_B = $bits(lst_entry_t) / 8;
	localparam int unsigned PTR_B = `PTR_W / 8;

	lst_id_t     lst_tgt;  // list entry this step touches
	lst_id_t     lst_idx;
	att_id_t     att_idx;
	int unsigned att_lane, lst_lane, lst_lo;
	att_entry_t  att_ent;
	lst_entry_t  lst_ent;

	always_comb begin
		case (upd_step)
			POP_WR:       lst_tgt = upd_next;   // successor of popped entry
			PUSH_SELF_WR: lst_tgt = upd_tol_id;
			default:      lst_tgt = uncomp_tail; // old tail for link
		endcase
	end

	assign lst_idx  = lst_tgt - 1'b1;
	assign att_idx  = upd_att_id - 1'b1;
	assign att_lane = att_idx % `ATT_PER_LINE;
	assign lst_lane = lst_idx % `LST_PER_LINE;
	assign lst_lo   = lst_lane * LST_B; // first byte of the entry

	always_comb begin
		att_ent = '0;
		lst_ent = '0;
		data    = '0;
		strb    = '0;
		addr    = `HAWK_LIST_BASE + addr_t'(lst_idx / `LST_PER_LINE) * `LINE_BYTES;
		case (upd_step)
			ATT_WR: begin
				att_ent.way = upd_way;
				att_ent.sts = (upd_dst == UNCOMP) ? STS_UNCOMP : STS_DALLOC;
				addr = `HAWK_ATT_BASE + addr_t'(att_idx / `ATT_PER_LINE) * `LINE_BYTES;
				data[att_lane*ATT_B*8 +: ATT_B*8] = att_ent;
				strb[att_lane*ATT_B +: ATT_B]     = '1; // whole entry
			end
			POP_WR: begin
				lst_ent.prev = upd_prev;
				data[lst_lo*8 +: LST_B*8]   = lst_ent;
				strb[lst_lo+PTR_B +: PTR_B] = '1; // prev only
			end
			PUSH_SELF_WR: begin
				lst_ent.prev = uncomp_tail;
				lst_ent.next = '0; // new tail points to null
				data[lst_lo*8 +: LST_B*8]   = lst_ent;
				strb[lst_lo +: 2*PTR_B]     = '1;
			end
			default: begin
				lst_ent.next = upd_tol_id; // old tail -> new entry
				data[lst_lo*8 +: LST_B*8]   = lst_ent;
				strb[lst_lo +: PTR_B]       = '1;
			end
		endcase
	end

endmodule

// ==== verilog/init_line_builder.sv ====
// combinational write for one init entry
// att entries get dalloc with way 0 and list entries form one free list 1..LIST_ENTRY_CNT
`include "hawk_consts.svh"

module init_line_builder (
	input  hawk_pkg::att_id_t init_entry,   // 1-based
	input  logic              init_is_list,
	output hawk_pkg::addr_t   addr,
	output hawk_pkg::line_t   data,
	output hawk_pkg::strb_t   strb
);
	import hawk_pkg::*;

	localparam int unsigned ATT_B = $bits(att_entry_t) / 8;
	localparam int unsigned LST_B = $bits(lst_entry_t) / 8;

	att_id_t     idx;                 // zero-based slot
	int unsigned att_lane, lst_lane;
	lst_entry_t  lst_ent;

	assign idx      = init_entry - 1'b1;
	assign att_lane = idx % `ATT_PER_LINE;
	assign lst_lane = idx % `LST_PER_LINE;

	always_comb begin
		lst_ent      = '0;
		lst_ent.way  = `HAWK_PPA_BASE + way_t'(idx); // one page per entry
		lst_ent.prev = lst_id_t'(idx);               // entry 1 gets null
		if (init_entry == att_id_t'(`LIST_ENTRY_CNT)) begin
			lst_ent.next = '0; // tail
		end else begin
			lst_ent.next = lst_id_t'(init_entry) + 1'b1;
		end
	end

	always_comb begin
		data = '0;
		strb = '0;
		if (init_is_list) begin
			addr = `HAWK_LIST_BASE + addr_t'(idx / `LST_PER_LINE) * `LINE_BYTES;
			data[lst_lane*LST_B*8 +: LST_B*8] = lst_ent;
			strb[lst_lane*LST_B +: LST_B]     = '1;
		end else begin
			addr = `HAWK_ATT_BASE + addr_t'(idx / `ATT_PER_LINE) * `LINE_BYTES;
			strb[att_lane*ATT_B +: ATT_B] = '1; // dalloc with way 0 is an all-zero lane
		end
	end

endmodule

// ==== verilog/tol_list_regs.sv ====
// head/tail pointers of the free and uncompressed lists
// 0 is null, an empty uncompressed list has a null tail
`include "hawk_consts.svh"

module tol_list_regs (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              init_list_end,
	input  logic              pop_free,
	input  hawk_pkg::lst_id_t pop_next,   // new free head
	input  logic              push_uncomp,
	input  hawk_pkg::lst_id_t push_id,    // appended entry
	output hawk_pkg::lst_id_t free_head,
	output hawk_pkg::lst_id_t free_tail,
	output hawk_pkg::lst_id_t uncomp_head,
	output hawk_pkg::lst_id_t uncomp_tail,
	output logic              uncomp_empty
);
	import hawk_pkg::*;

	assign uncomp_empty = (uncomp_tail == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			free_head   <= '0;
			free_tail   <= '0;
			uncomp_head <= '0;
			uncomp_tail <= '0;
		end else begin
			if (init_list_end) begin
				free_head <= lst_id_t'(1);              // whole table is free
				free_tail <= lst_id_t'(`LIST_ENTRY_CNT);
			end else if (pop_free) begin
				free_head <= pop_next; // pop front
			end
			if (push_uncomp) begin
				uncomp_tail <= push_id; // push back
				if (uncomp_empty) begin
					uncomp_head <= push_id;
				end
			end
		end
	end

endmodule

// ==== verilog/wr_resp_tracker.sv ====
// counts accepted write addresses not yet answered
// in-order responses, bready implied; bus_error is sticky until reset
module wr_resp_tracker #(
	parameter int unsigned CNT_W = 7 // up to 127 outstanding
) (
	input  logic            clk_i,
	input  logic            rst_ni,
	input  logic            awvalid,
	input  logic            awready,
	input  logic            bvalid,
	input  hawk_pkg::resp_t bresp,
	output logic            all_resp_done,
	output logic            bus_error
);
	logic [CNT_W-1:0] pend_cnt;
	logic             aw_acc, b_good;

	assign aw_acc        = awvalid && awready;
	assign b_good        = bvalid && (bresp == '0);
	assign all_resp_done = (pend_cnt == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			pend_cnt  <= '0;
			bus_error <= 1'b0;
		end else begin
			if (aw_acc && !b_good) begin
				pend_cnt <= pend_cnt + 1'b1;
			end else if (b_good && !aw_acc && !all_resp_done) begin
				pend_cnt <= pend_cnt - 1'b1;
			end // both at once, no change
			if ((bvalid && bresp != '0) || (b_good && all_resp_done)) begin
				bus_error <= 1'b1; // bad code or unexpected response
			end
		end
	end

endmodule

// ==== verilog/hawk_pkg.sv ====
// shared types for the page-write manager
// entry layouts mirror the in-memory table format, plain little-endian lanes
`include "hawk_consts.svh"

package hawk_pkg;

	typedef logic [63:0]               addr_t; // byte address
	typedef logic [`LINE_BYTES*8-1:0]  line_t;
	typedef logic [`LINE_BYTES-1:0]    strb_t;
	typedef logic [1:0]                resp_t; // 0 is okay

	// one spare bit so the init counter can run past the last id
	typedef logic [$clog2(`ATT_ENTRY_CNT):0] att_id_t;
	typedef logic [`PTR_W-1:0]               lst_id_t;
	typedef logic [`WAY_W-1:0]               way_t;

	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0,
		STS_UNCOMP = 2'd1,
		STS_COMP   = 2'd2
	} att_sts_e;

	typedef enum logic [1:0] {
		FREE   = 2'd0,
		UNCOMP = 2'd1,
		COMP   = 2'd2
	} list_sel_e;

	typedef struct packed {
		logic [11:0] zpd_cnt;
		way_t        way;
		att_sts_e    sts;    // low bits
	} att_entry_t;

	typedef struct packed {
		logic [13:0] rsvd;
		way_t        way;
		lst_id_t     prev;   // bytes 4..7
		lst_id_t     next;   // bytes 0..3
	} lst_entry_t;

	typedef enum logic [1:0] {ATT_WR, POP_WR, PUSH_SELF_WR, PUSH_LINK_WR} upd_step_e;

	typedef enum logic [2:0] {
		IDLE, INIT_ATT, WAIT_ATT, INIT_LIST, WAIT_LIST, UPD_AW, UPD_W, WAIT_RESP
	} pgwr_state_e;

endpackage

// ==== verilog/hawk_consts.svh ====
// table layout for the page-write manager
// ids are 1-based and 0 is the null pointer
// att and list regions must be line aligned and must not overlap
`ifndef HAWK_CONSTS_SVH
`define HAWK_CONSTS_SVH

// memory map
`define HAWK_ATT_BASE   64'h0000_0000_8000_0000 // att entry 1
`define HAWK_LIST_BASE  64'h0000_0000_8000_0100 // list entry 1, clear of 16 att entries
`define HAWK_PPA_BASE   50'h0_0000_0008_0100    // ppn handed to list entry 1

// table sizes
`define ATT_ENTRY_CNT   16
`define LIST_ENTRY_CNT  8

// line geometry
`define LINE_BYTES      64
`define ATT_PER_LINE    8  // 8B att entries
`define LST_PER_LINE    4  // 16B list entries

// field widths
`define PTR_W           32 // prev/next pointers
`define WAY_W           50 // physical page number

`endif
